// File: src/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// Data path and address width
`define XLEN       32

// Register index width, 32 integer registers
`define REG_AW     5

// Instruction memory size in words
`define IMEM_DEPTH 256
`define IMEM_AW    $clog2(`IMEM_DEPTH)

// First fetch address after reset
`define RESET_PC   32'h0000_0000

`endif

// File: src/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    // Operand source in EX
    typedef enum logic [1:0] {
        FWD_REG      = 2'd0,
        FWD_FROM_MEM = 2'd1,
        FWD_FROM_WB  = 2'd2
    } fwd_sel_e;

    // All zero is a bubble
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    branch_ne;
        logic    alu_src_imm;
        alu_op_e alu_op;
    } ctrl_t;

endpackage

`default_nettype wire

// File: src/ex_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

interface ex_mem_if import rv_pkg::*; ();

    logic [`XLEN-1:0]   alu_result;
    logic [`XLEN-1:0]   store_data;
    logic [`REG_AW-1:0] rd;
    ctrl_t              ctrl;
    logic               valid;

    // EX/MEM register side
    modport ex (output alu_result, store_data, rd, ctrl, valid);

    // Memory stage and hazard unit
    modport mem (input alu_result, store_data, rd, ctrl, valid);

endinterface

`default_nettype wire

// File: src/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module fetch_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                imem_we,
    input  logic [`IMEM_AW-1:0] imem_addr,
    input  logic [`XLEN-1:0]    imem_data,
    input  logic                stall,
    input  logic                flush,
    input  logic                branch_taken,
    input  logic [`XLEN-1:0]    branch_target,
    output logic [`XLEN-1:0]    if_pc,
    output logic [`XLEN-1:0]    if_instr
);

    logic [`XLEN-1:0] imem [`IMEM_DEPTH];
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_next;
    logic [`XLEN-1:0] fetch_word;

    // Word addressed, read without a clock
    assign fetch_word = imem[pc[`IMEM_AW+1:2]];
    assign pc_next    = branch_taken ? branch_target : pc + `XLEN'(4);

    // Program load, only while held in reset
    always_ff @(posedge clk) begin
        if (rst && imem_we) begin
            imem[imem_addr] <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    // IF/ID, a zero word decodes as a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            if_instr <= '0;
        end else if (!stall) begin
            if_instr <= flush ? '0 : fetch_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_pc <= pc;
        end
    end

endmodule

`default_nettype wire

// File: src/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module decode_stage import rv_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [`XLEN-1:0]   if_pc,
    input  logic [`XLEN-1:0]   if_instr,
    input  logic               stall,
    input  logic               bubble,
    input  logic               flush,
    input  logic               wb_en,
    input  logic [`REG_AW-1:0] wb_rd,
    input  logic [`XLEN-1:0]   wb_data,
    output logic [`XLEN-1:0]   idex_pc,
    output logic [`XLEN-1:0]   idex_rs1_val,
    output logic [`XLEN-1:0]   idex_rs2_val,
    output logic [`XLEN-1:0]   idex_imm,
    output logic [`REG_AW-1:0] idex_rs1,
    output logic [`REG_AW-1:0] idex_rs2,
    output logic [`REG_AW-1:0] idex_rd,
    output ctrl_t              idex_ctrl,
    output logic               id_valid,
    output logic [`REG_AW-1:0] id_rs1,
    output logic [`REG_AW-1:0] id_rs2
);

    logic [`XLEN-1:0]   regs [2**`REG_AW];
    logic [`XLEN-1:0]   rs1_val;
    logic [`XLEN-1:0]   rs2_val;
    logic [`XLEN-1:0]   imm;
    logic [`REG_AW-1:0] rd;
    logic [2:0]         funct3;
    ctrl_t              ctrl;
    logic               instr_legal;

    assign id_rs1 = if_instr[19:15];
    assign id_rs2 = if_instr[24:20];
    assign rd     = if_instr[11:7];
    assign funct3 = if_instr[14:12];

    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    // Main decoder and immediate select, I-type unless overridden
    always_comb begin
        ctrl        = '0;
        instr_legal = 1'b1;
        imm         = {{20{if_instr[31]}}, if_instr[31:20]};
        case (opcode_e'(if_instr[6:0]))
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_from_funct(funct3, if_instr[30]);
            end
            OPC_OP_IMM: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = alu_from_funct(funct3, 1'b0);
            end
            OPC_LOAD: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OPC_STORE: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
            end
            OPC_BRANCH: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = funct3[0];
                imm = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                       if_instr[30:25], if_instr[11:8], 1'b0};
            end
            default: begin
                instr_legal = 1'b0;
            end
        endcase
    end

    // x0 is never written and stays zero from reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**`REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Same-cycle writeback bypass
    assign rs1_val = (wb_en && wb_rd != '0 && wb_rd == id_rs1) ? wb_data : regs[id_rs1];
    assign rs2_val = (wb_en && wb_rd != '0 && wb_rd == id_rs2) ? wb_data : regs[id_rs2];

    always_ff @(posedge clk) begin
        if (rst || bubble || flush) begin
            idex_ctrl <= '0;
            id_valid  <= 1'b0;
        end else if (!stall) begin
            idex_ctrl <= ctrl;
            id_valid  <= instr_legal;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            idex_pc      <= if_pc;
            idex_rs1_val <= rs1_val;
            idex_rs2_val <= rs2_val;
            idex_imm     <= imm;
            idex_rs1     <= id_rs1;
            idex_rs2     <= id_rs2;
            idex_rd      <= rd;
        end
    end

endmodule

`default_nettype wire

// File: src/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module execute_stage import rv_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [`XLEN-1:0]   idex_pc,
    input  logic [`XLEN-1:0]   idex_rs1_val,
    input  logic [`XLEN-1:0]   idex_rs2_val,
    input  logic [`XLEN-1:0]   idex_imm,
    input  logic [`REG_AW-1:0] idex_rd,
    input  ctrl_t              idex_ctrl,
    input  logic               id_valid,
    input  fwd_sel_e           fwd_a,
    input  fwd_sel_e           fwd_b,
    input  logic               stall,
    input  logic [`XLEN-1:0]   wb_data,
    ex_mem_if.ex               ex,
    output logic               branch_taken,
    output logic [`XLEN-1:0]   branch_target
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] rs2_fwd;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_out;

    function automatic logic [`XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                 input logic [`XLEN-1:0] reg_val,
                                                 input logic [`XLEN-1:0] mem_val,
                                                 input logic [`XLEN-1:0] wb_val);
        case (sel)
            FWD_FROM_MEM: return mem_val;
            FWD_FROM_WB:  return wb_val;
            default:      return reg_val;
        endcase
    endfunction

    // MEM source is the ALU result already in EX/MEM
    assign op_a    = fwd_mux(fwd_a, idex_rs1_val, ex.alu_result, wb_data);
    assign rs2_fwd = fwd_mux(fwd_b, idex_rs2_val, ex.alu_result, wb_data);
    assign op_b    = idex_ctrl.alu_src_imm ? idex_imm : rs2_fwd;

    always_comb begin
        case (idex_ctrl.alu_op)
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_XOR: alu_out = op_a ^ op_b;
            ALU_SLT: alu_out = `XLEN'($signed(op_a) < $signed(op_b));
            default: alu_out = op_a + op_b;
        endcase
    end

    // BEQ and BNE differ only in the sense of the compare
    assign branch_target = idex_pc + idex_imm;
    assign branch_taken  = id_valid && idex_ctrl.branch &&
                           ((op_a == rs2_fwd) != idex_ctrl.branch_ne);

    always_ff @(posedge clk) begin
        if (rst) begin
            ex.ctrl  <= '0;
            ex.valid <= 1'b0;
        end else if (!stall) begin
            ex.ctrl  <= idex_ctrl;
            ex.valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex.alu_result <= alu_out;
            ex.store_data <= rs2_fwd;
            ex.rd         <= idex_rd;
        end
    end

endmodule

`default_nettype wire

// File: src/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module memory_stage (
    input  logic               clk,
    input  logic               rst,
    ex_mem_if.mem              mem,
    input  logic               stall,
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output logic [`XLEN-1:0]   wb_adr,
    output logic [`XLEN-1:0]   wb_wdata,
    input  logic [`XLEN-1:0]   wb_rdata,
    input  logic               wb_ack,
    output logic               bus_wait,
    output logic               wb_en,
    output logic [`REG_AW-1:0] wb_rd,
    output logic [`XLEN-1:0]   wb_data
);

    typedef enum logic {
        BUS_READY,
        BUS_RECOVER
    } bus_state_e;

    bus_state_e       state;
    logic             req;
    logic [`XLEN-1:0] alu_q;
    logic [`XLEN-1:0] load_q;
    logic             mem_to_reg_q;

    assign req = mem.valid && (mem.ctrl.mem_read || mem.ctrl.mem_write);

    // Strobe stays low for a cycle after every ack
    assign wb_stb   = req && (state == BUS_READY);
    assign wb_cyc   = wb_stb;
    assign wb_we    = mem.ctrl.mem_write;
    assign wb_adr   = mem.alu_result;
    assign wb_wdata = mem.store_data;
    assign bus_wait = req && !(wb_stb && wb_ack);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= BUS_READY;
        end else begin
            state <= (wb_stb && wb_ack) ? BUS_RECOVER : BUS_READY;
        end
    end

    // MEM/WB, load data captured on the ack edge
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_en <= 1'b0;
        end else if (!stall) begin
            wb_en <= mem.valid && mem.ctrl.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wb_rd        <= mem.rd;
            alu_q        <= mem.alu_result;
            load_q       <= wb_rdata;
            mem_to_reg_q <= mem.ctrl.mem_read;
        end
    end

    assign wb_data = mem_to_reg_q ? load_q : alu_q;

endmodule

`default_nettype wire

// File: src/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module hazard_unit import rv_pkg::*; (
    input  logic [`REG_AW-1:0] idex_rs1,
    input  logic [`REG_AW-1:0] idex_rs2,
    input  logic [`REG_AW-1:0] idex_rd,
    input  logic               idex_mem_read,
    input  logic [`REG_AW-1:0] id_rs1,
    input  logic [`REG_AW-1:0] id_rs2,
    ex_mem_if.mem              mem,
    input  logic               wb_en,
    input  logic [`REG_AW-1:0] wb_rd,
    input  logic               branch_taken,
    input  logic               bus_wait,
    output fwd_sel_e           fwd_a,
    output fwd_sel_e           fwd_b,
    output logic               stall,
    output logic               bubble,
    output logic               flush
);

    logic load_use;

    // Younger result in MEM wins over WB
    function automatic fwd_sel_e fwd_for(input logic [`REG_AW-1:0] rs,
                                         input logic [`REG_AW-1:0] mem_rd,
                                         input logic               mem_we,
                                         input logic [`REG_AW-1:0] last_rd,
                                         input logic               last_we);
        if (rs == '0) begin
            return FWD_REG;
        end
        if (mem_we && mem_rd == rs) begin
            return FWD_FROM_MEM;
        end
        if (last_we && last_rd == rs) begin
            return FWD_FROM_WB;
        end
        return FWD_REG;
    endfunction

    assign fwd_a = fwd_for(idex_rs1, mem.rd, mem.ctrl.reg_write, wb_rd, wb_en);
    assign fwd_b = fwd_for(idex_rs2, mem.rd, mem.ctrl.reg_write, wb_rd, wb_en);

    // Load in EX feeding the instruction in ID
    assign load_use = idex_mem_read && idex_rd != '0 &&
                      (idex_rd == id_rs1 || idex_rd == id_rs2);

    // A waiting bus access freezes everything, including the flush
    assign stall  = bus_wait || load_use;
    assign bubble = load_use && !bus_wait;
    assign flush  = branch_taken && !bus_wait;

endmodule

`default_nettype wire

// File: src/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_core import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                imem_we,
    input  logic [`IMEM_AW-1:0] imem_addr,
    input  logic [`XLEN-1:0]    imem_data,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic                wb_we,
    output logic [`XLEN-1:0]    wb_adr,
    output logic [`XLEN-1:0]    wb_wdata,
    input  logic [`XLEN-1:0]    wb_rdata,
    input  logic                wb_ack
);

    // IF/ID
    logic [`XLEN-1:0]   if_pc;
    logic [`XLEN-1:0]   if_instr;

    // ID/EX and decode fields
    logic [`XLEN-1:0]   idex_pc;
    logic [`XLEN-1:0]   idex_rs1_val;
    logic [`XLEN-1:0]   idex_rs2_val;
    logic [`XLEN-1:0]   idex_imm;
    logic [`REG_AW-1:0] idex_rs1;
    logic [`REG_AW-1:0] idex_rs2;
    logic [`REG_AW-1:0] idex_rd;
    ctrl_t              idex_ctrl;
    logic               id_valid;
    logic [`REG_AW-1:0] id_rs1;
    logic [`REG_AW-1:0] id_rs2;

    // Hazard control
    fwd_sel_e           fwd_a;
    fwd_sel_e           fwd_b;
    logic               stall;
    logic               bubble;
    logic               flush;
    logic               bus_wait;
    logic               branch_taken;
    logic [`XLEN-1:0]   branch_target;

    // Writeback
    logic               wb_en;
    logic [`REG_AW-1:0] wb_rd;
    logic [`XLEN-1:0]   wb_data;

    ex_mem_if ex_mem ();

    fetch_stage fetch_i (.*);

    decode_stage decode_i (.*);

    // Back end only freezes on the bus, load-use keeps it moving
    execute_stage execute_i (.ex(ex_mem.ex), .stall(bus_wait), .*);

    memory_stage memory_i (.mem(ex_mem.mem), .stall(bus_wait), .*);

    hazard_unit hazard_i (.mem(ex_mem.mem), .idex_mem_read(idex_ctrl.mem_read), .*);

endmodule

`default_nettype wire

// File: sim/rv_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_core_asserts (
    input logic             clk,
    input logic             rst,
    input logic             wb_cyc,
    input logic             wb_stb,
    input logic             wb_we,
    input logic [`XLEN-1:0] wb_adr,
    input logic [`XLEN-1:0] wb_wdata,
    input logic             wb_ack
);

    // Request held steady until the slave answers
    req_stable: assert property (@(posedge clk) disable iff (rst)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_wdata))
        else $error("Wishbone request changed before ack");

    stb_drops: assert property (@(posedge clk) disable iff (rst)
        wb_stb && wb_ack |=> !wb_cyc && !wb_stb)
        else $error("wb_cyc or wb_stb still high in the cycle after ack");

    cyc_low_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !wb_cyc)
        else $error("wb_cyc high during reset");

endmodule

bind rv_core rv_core_asserts asserts_i (
    .clk(clk),
    .rst(rst),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_we(wb_we),
    .wb_adr(wb_adr),
    .wb_wdata(wb_wdata),
    .wb_ack(wb_ack)
);

`default_nettype wire

// File: sim/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module tb_rv_core import rv_pkg::*; ();

    logic                clk;
    logic                rst;
    logic                imem_we;
    logic [`IMEM_AW-1:0] imem_addr;
    logic [`XLEN-1:0]    imem_data;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [`XLEN-1:0]    wb_adr;
    logic [`XLEN-1:0]    wb_wdata;
    logic [`XLEN-1:0]    wb_rdata = '0;
    logic                wb_ack = 1'b0;

    // Program, expected stores and recorded stores
    logic [`XLEN-1:0] prog [$];
    logic [`XLEN-1:0] exp_adr [$];
    logic [`XLEN-1:0] exp_dat [$];
    logic [`XLEN-1:0] st_adr [$];
    logic [`XLEN-1:0] st_dat [$];
    logic [`XLEN-1:0] base_adr [$];
    logic [`XLEN-1:0] base_dat [$];
    logic [`XLEN-1:0] mregs [32];
    logic [`XLEN-1:0] dmem [256];

    // Wishbone slave model state
    logic             random_delays = 1'b0;
    logic [31:0]      rng_state = 32'd15;
    logic             delay_armed = 1'b0;
    int               delay_left = 0;
    logic [`XLEN-1:0] acc_adr;
    logic [`XLEN-1:0] acc_dat;
    logic             acc_we;

    int err_count = 0;
    int tests_failed = 0;
    int tests_run = 0;

    rv_core dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Preload word depends on the full byte address
    function automatic logic [`XLEN-1:0] fill_word(input int idx);
        logic [31:0] a;
        a = idx << 2;
        return {a[15:0] ^ 16'hA5C3, ~a[15:0]};
    endfunction

    function automatic logic [31:0] r_type(input alu_op_e op, input int rd, input int rs1,
                                           input int rs2);
        logic [2:0] f3;
        logic [6:0] f7;
        f7 = 7'b0000000;
        case (op)
            ALU_SUB: begin
                f3 = 3'b000;
                f7 = 7'b0100000;
            end
            ALU_AND: f3 = 3'b111;
            ALU_OR:  f3 = 3'b110;
            ALU_XOR: f3 = 3'b100;
            ALU_SLT: f3 = 3'b010;
            default: f3 = 3'b000;
        endcase
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input opcode_e opc, input logic [2:0] f3,
                                           input int rd, input int rs1, input int imm);
        logic [31:0] iv;
        iv = imm;
        return {iv[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
        logic [31:0] iv;
        iv = imm;
        return {iv[11:5], rs2[4:0], rs1[4:0], 3'b010, iv[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic ne, input int rs1, input int rs2,
                                           input int imm);
        logic [31:0] iv;
        iv = imm;
        return {iv[12], iv[10:5], rs2[4:0], rs1[4:0], 2'b00, ne, iv[4:1], iv[11], OPC_BRANCH};
    endfunction

    // RV32I semantics of the supported operations
    function automatic logic [`XLEN-1:0] alu_ref(input alu_op_e op, input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
        case (op)
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLT: return ($signed(a) < $signed(b)) ? `XLEN'(1) : `XLEN'(0);
            default: return a + b;
        endcase
    endfunction

    // Slave answers on the falling edge and logs a store after its ack edge
    always @(negedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
            delay_armed = 1'b0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
            delay_armed = 1'b0;
            if (acc_we) begin
                dmem[acc_adr[9:2]] = acc_dat;
                st_adr.push_back(acc_adr);
                st_dat.push_back(acc_dat);
            end
        end else if (wb_cyc && wb_stb) begin
            if (!delay_armed) begin
                rng_state = lcg_next(rng_state);
                delay_left = random_delays ? int'(rng_state[17:16]) : 0;
                delay_armed = 1'b1;
            end
            if (delay_left == 0) begin
                wb_ack <= 1'b1;
                wb_rdata <= dmem[wb_adr[9:2]];
                acc_adr = wb_adr;
                acc_dat = wb_wdata;
                acc_we = wb_we;
            end else begin
                delay_left--;
            end
        end
    end

    task automatic check_word(input string name, input logic [`XLEN-1:0] expected,
                              input logic [`XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, got %h", name, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_store(input string name, input logic [`XLEN-1:0] exp_a,
                               input logic [`XLEN-1:0] exp_d, input logic [`XLEN-1:0] act_a,
                               input logic [`XLEN-1:0] act_d);
        if (act_a !== exp_a || act_d !== exp_d) begin
            $display("ERR %s: expected store [%h] = %h, got [%h] = %h",
                     name, exp_a, exp_d, act_a, act_d);
            err_count++;
        end
    endtask

    task automatic expect_store(input int adr, input logic [`XLEN-1:0] dat);
        exp_adr.push_back(adr);
        exp_dat.push_back(dat);
    endtask

    task automatic new_program();
        prog.delete();
        exp_adr.delete();
        exp_dat.delete();
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
    endtask

    // One ALU step against the model
    // A negative slot leaves the result unstored
    task automatic alu_step(input alu_op_e op, input int rd, input int rs1, input int rs2,
                            input logic use_imm, input int imm, input int slot);
        logic [`XLEN-1:0] res;
        if (use_imm) begin
            prog.push_back(i_type(OPC_OP_IMM, 3'b000, rd, rs1, imm));
            res = alu_ref(ALU_ADD, mregs[rs1], imm);
        end else begin
            prog.push_back(r_type(op, rd, rs1, rs2));
            res = alu_ref(op, mregs[rs1], mregs[rs2]);
        end
        if (rd != 0) begin
            mregs[rd] = res;
        end
        if (slot >= 0) begin
            prog.push_back(s_type(rd, 0, slot * 4));
            expect_store(slot * 4, mregs[rd]);
        end
    endtask

    // Loads the program in reset and waits for the expected stores
    task automatic run_program(input string name, input int max_cycles);
        int load_cycles;
        int cycles;
        @(negedge clk);
        rst = 1'b1;
        prog.push_back(b_type(1'b0, 0, 0, 0));
        prog.push_back('0);
        prog.push_back('0);
        st_adr.delete();
        st_dat.delete();
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(i);
        end
        load_cycles = (prog.size() > 8) ? prog.size() : 8;
        for (int i = 0; i < load_cycles; i++) begin
            imem_we = (i < prog.size());
            imem_addr = i[`IMEM_AW-1:0];
            imem_data = (i < prog.size()) ? prog[i] : '0;
            @(negedge clk);
        end
        imem_we = 1'b0;
        rst = 1'b0;
        cycles = 0;
        while (st_adr.size() < exp_adr.size() && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (st_adr.size() < exp_adr.size()) begin
            $display("%s: timed out after %0d cycles with %0d of %0d stores seen",
                     name, cycles, st_adr.size(), exp_adr.size());
            err_count++;
        end
        // Window for stores that should never appear
        repeat (20) @(negedge clk);
        check_word({name, " store count"}, exp_adr.size(), st_adr.size());
        for (int i = 0; i < exp_adr.size() && i < st_adr.size(); i++) begin
            check_store(name, exp_adr[i], exp_dat[i], st_adr[i], st_dat[i]);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count != errs_before) begin
            tests_failed++;
        end
        $display("test %s finished with %0d failed checks", name, err_count - errs_before);
    endtask

    task automatic build_alu_program();
        new_program();
        alu_step(ALU_ADD, 1, 0, 0, 1'b1, 23, -1);
        alu_step(ALU_ADD, 2, 1, 0, 1'b1, -30, 0);
        alu_step(ALU_ADD, 3, 1, 2, 1'b0, 0, -1);
        alu_step(ALU_SUB, 4, 3, 2, 1'b0, 0, 1);
        alu_step(ALU_AND, 5, 4, 3, 1'b0, 0, 2);
        alu_step(ALU_OR, 6, 5, 1, 1'b0, 0, 3);
        alu_step(ALU_XOR, 7, 6, 2, 1'b0, 0, -1);
        alu_step(ALU_SLT, 8, 7, 1, 1'b0, 0, 4);
        alu_step(ALU_SLT, 9, 2, 0, 1'b0, 0, 5);
        alu_step(ALU_ADD, 10, 8, 9, 1'b0, 0, 6);
    endtask

    task automatic alu_forwarding();
        int errs;
        errs = err_count;
        build_alu_program();
        random_delays = 1'b0;
        run_program("alu_forwarding", 400);
        base_adr = st_adr;
        base_dat = st_dat;
        report_test("alu_forwarding", errs);
    endtask

    task automatic load_use();
        int errs;
        errs = err_count;
        new_program();
        prog.push_back(i_type(OPC_OP_IMM, 3'b000, 5, 0, 64));
        prog.push_back(i_type(OPC_LOAD, 3'b010, 1, 5, 12));
        prog.push_back(r_type(ALU_ADD, 2, 1, 5));
        prog.push_back(s_type(2, 0, 0));
        prog.push_back(i_type(OPC_LOAD, 3'b010, 6, 5, 16));
        prog.push_back(r_type(ALU_SUB, 7, 5, 6));
        prog.push_back(s_type(7, 0, 4));
        prog.push_back(s_type(1, 0, 8));
        expect_store(0, fill_word(19) + 32'd64);
        expect_store(4, 32'd64 - fill_word(20));
        expect_store(8, fill_word(19));
        random_delays = 1'b0;
        run_program("load_use", 400);
        report_test("load_use", errs);
    endtask

    task automatic branches();
        int errs;
        errs = err_count;
        new_program();
        prog.push_back(i_type(OPC_OP_IMM, 3'b000, 1, 0, 5));
        prog.push_back(i_type(OPC_OP_IMM, 3'b000, 2, 0, 5));
        prog.push_back(i_type(OPC_OP_IMM, 3'b000, 3, 0, 9));
        // Taken BEQ skips the next two stores
        prog.push_back(b_type(1'b0, 1, 2, 12));
        prog.push_back(s_type(3, 0, 0));
        prog.push_back(s_type(3, 0, 4));
        prog.push_back(s_type(1, 0, 8));
        prog.push_back(b_type(1'b1, 1, 2, 8));
        prog.push_back(s_type(2, 0, 12));
        prog.push_back(s_type(3, 0, 16));
        expect_store(8, 32'd5);
        expect_store(12, 32'd5);
        expect_store(16, 32'd9);
        random_delays = 1'b0;
        run_program("branches", 400);
        report_test("branches", errs);
    endtask

    task automatic bus_backpressure();
        int errs;
        errs = err_count;
        build_alu_program();
        random_delays = 1'b1;
        rng_state = 32'd15;
        run_program("bus_backpressure", 1000);
        check_word("bus_backpressure sequence length", base_adr.size(), st_adr.size());
        for (int i = 0; i < base_adr.size() && i < st_adr.size(); i++) begin
            check_store("bus_backpressure", base_adr[i], base_dat[i], st_adr[i], st_dat[i]);
        end
        report_test("bus_backpressure", errs);
    endtask

    task automatic x0_ignored();
        int errs;
        errs = err_count;
        new_program();
        prog.push_back(i_type(OPC_OP_IMM, 3'b000, 0, 0, 77));
        prog.push_back(s_type(0, 0, 0));
        prog.push_back(i_type(OPC_OP_IMM, 3'b000, 2, 0, 1));
        prog.push_back(s_type(2, 0, 4));
        // x0 read back from the register file long after the write retired
        prog.push_back(s_type(0, 0, 8));
        expect_store(0, 32'd0);
        expect_store(4, 32'd1);
        expect_store(8, 32'd0);
        random_delays = 1'b0;
        run_program("x0_ignored", 400);
        report_test("x0_ignored", errs);
    endtask

    initial begin
        rst = 1'b1;
        imem_we = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        alu_forwarding();
        load_use();
        branches();
        bus_backpressure();
        x0_ignored();
        $display("%0d tests run, %0d failed, %0d failed checks",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+src
src/rv_pkg.sv
src/ex_mem_if.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/hazard_unit.sv
src/rv_core.sv
sim/rv_core_asserts.sv
sim/tb_rv_core.sv

// File: run.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and check the log
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module tb_rv_core -o tb_rv_core_sim

./obj_dir/tb_rv_core_sim | tee sim.log

if grep -qx "No errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
